// File: compile.f
design/fetchPkg.sv
design/fetchBlockMemory.sv
design/branchTargetBuffer.sv
design/fetchSequencer.sv
design/instrFetch.sv
tb/fetchSequencer_checker.sv
tb/tbInstrFetch.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tbInstrFetch
FILELIST  = compile.f
OBJDIR    = obj_dir
SIM       = $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# Pass only if the simulation printed the pass line
run: compile
	@out=$$(./$(SIM)); echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(OBJDIR)

// File: tb/tbInstrFetch.sv
`timescale 1ns/1ps
`default_nettype none

module tbInstrFetch import fetchPkg::*; ();

    localparam int MEM_BLOCKS      = 48;
    localparam int BTB_ENTRIES     = 16;
    localparam int MIDX_W          = $clog2(MEM_BLOCKS);
    localparam int IDX_W           = $clog2(BTB_ENTRIES);
    localparam int RESET_CYCLES    = 8;
    localparam int SEQ_CYCLES      = 12;
    localparam int TRAIN_COUNT     = 10;
    localparam int RUN_CYCLES      = 30;
    localparam int REDIRECT_ROUNDS = 6;
    localparam int RANDOM_CYCLES   = 60;
    // All phases back to back, plus margin
    localparam int TOTAL_CYCLES = RESET_CYCLES + MEM_BLOCKS + SEQ_CYCLES + TRAIN_COUNT + 8
        + 2 * (RUN_CYCLES + 1) + REDIRECT_ROUNDS * 5 + 11 + RANDOM_CYCLES + 3 + 200;

    typedef struct packed {
        logic [PC_W-1:0]    pc;
        logic [FID_W-1:0]   fid;
        logic [BLOCK_W-1:0] instrs;
        logic [SLOT_W-1:0]  firstSlot;
        logic [SLOT_W-1:0]  lastSlot;
        logic               predTaken;
        logic [PC_W-1:0]    predTarget;
        fetchFaultT         fault;
    } packetT;

    logic               clk;
    logic               rst;
    logic               fetchEn;
    logic               loadValid;
    logic [BADDR_W-1:0] loadAddr;
    logic [BLOCK_W-1:0] loadData;
    logic               updValid;
    logic [PC_W-1:0]    updPc;
    logic [PC_W-1:0]    updTarget;
    logic               updTaken;
    logic               updIsJump;
    logic               redirectValid;
    logic [PC_W-1:0]    redirectPc;
    logic [FID_W-1:0]   redirectFid;
    logic               outValid;
    logic [PC_W-1:0]    outPc;
    logic [FID_W-1:0]   outFid;
    logic [BLOCK_W-1:0] outInstrs;
    logic [SLOT_W-1:0]  outFirstSlot;
    logic [SLOT_W-1:0]  outLastSlot;
    logic               outPredTaken;
    logic [PC_W-1:0]    outPredTarget;
    fetchFaultT         outFault;

    // Model of memory, BTB and sequencer
    logic [BLOCK_W-1:0] modelMem  [MEM_BLOCKS];
    logic               btbValid  [BTB_ENTRIES];
    logic [BADDR_W-1:0] btbBlock  [BTB_ENTRIES];
    logic [SLOT_W-1:0]  btbSlot   [BTB_ENTRIES];
    logic [PC_W-1:0]    btbTarget [BTB_ENTRIES];
    logic               btbJump   [BTB_ENTRIES];
    logic [1:0]         btbCtr    [BTB_ENTRIES];
    logic [PC_W-1:0]    modelPc;
    logic [FID_W-1:0]   modelFid;
    logic               modelFaulted;
    logic [PC_W-1:0]    trainedPc [TRAIN_COUNT];

    // Packet fetched this cycle, and the one the DUT shows this cycle
    logic   pendValid;
    logic   shownValid;
    packetT pendPkt;
    packetT shownPkt;

    logic [31:0] lcgState = 32'd11;

    instrFetch #(
        .MEM_BLOCKS  (MEM_BLOCKS),
        .BTB_ENTRIES (BTB_ENTRIES)
    ) instrFetch_inst (
        .clk (clk), .rst (rst), .fetchEn (fetchEn),
        .loadValid (loadValid), .loadAddr (loadAddr), .loadData (loadData),
        .updValid (updValid), .updPc (updPc), .updTarget (updTarget),
        .updTaken (updTaken), .updIsJump (updIsJump),
        .redirectValid (redirectValid), .redirectPc (redirectPc), .redirectFid (redirectFid),
        .outValid (outValid), .outPc (outPc), .outFid (outFid), .outInstrs (outInstrs),
        .outFirstSlot (outFirstSlot), .outLastSlot (outLastSlot),
        .outPredTaken (outPredTaken), .outPredTarget (outPredTarget), .outFault (outFault)
    );

    always #10 clk = ~clk;

    function automatic logic [15:0] lcgNext();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState[31:16];
    endfunction

    function automatic logic randBit();
        logic [15:0] r;
        r = lcgNext();
        return r[12];
    endfunction

    // Somewhere in blocks 0 to 39, any slot
    function automatic logic [PC_W-1:0] randPc();
        return lcgNext() % 16'd320;
    endfunction

    function automatic logic [BLOCK_W-1:0] randomBlock();
        logic [BLOCK_W-1:0] data;
        for (int s = 0; s < BLOCK_SLOTS; s++) begin
            data[s*PARCEL_W +: PARCEL_W] = lcgNext();
        end
        return data;
    endfunction

    function automatic packetT refPacket(input logic [PC_W-1:0] pc, input logic [FID_W-1:0] fid,
                                         output logic [PC_W-1:0] nextPc);
        packetT p;
        logic [BADDR_W-1:0] blk;
        logic [IDX_W-1:0] idx;
        logic hit;
        blk = pc[PC_W-1:SLOT_W];
        idx = blk[IDX_W-1:0];
        p.pc         = pc;
        p.fid        = fid;
        p.firstSlot  = pc[SLOT_W-1:0];
        p.instrs     = '0;
        p.lastSlot   = SLOT_W'(BLOCK_SLOTS - 1);
        p.predTaken  = 1'b0;
        p.predTarget = '0;
        p.fault      = FAULT_NONE;
        nextPc       = pc;
        if (32'(blk) >= MEM_BLOCKS) begin
            p.fault = FAULT_ACCESS;
        end else begin
            p.instrs = modelMem[blk[MIDX_W-1:0]];
            hit = btbValid[idx] && btbBlock[idx] == blk && btbSlot[idx] >= pc[SLOT_W-1:0];
            if (hit && (btbJump[idx] || btbCtr[idx] >= 2'd2)) begin
                p.predTaken  = 1'b1;
                p.lastSlot   = btbSlot[idx];
                p.predTarget = btbTarget[idx];
                nextPc       = btbTarget[idx];
            end else begin
                nextPc = {pc[PC_W-1:SLOT_W], SLOT_W'(0)} + PC_W'(BLOCK_SLOTS);
            end
        end
        return p;
    endfunction

    task automatic trainModel(input logic [PC_W-1:0] pc, input logic [PC_W-1:0] target,
                              input logic taken, input logic isJump);
        logic [IDX_W-1:0] idx;
        idx = pc[SLOT_W+IDX_W-1:SLOT_W];
        if (btbValid[idx] && btbBlock[idx] == pc[PC_W-1:SLOT_W]) begin
            btbTarget[idx] = target;
            btbJump[idx]   = isJump;
            if (taken) begin
                btbCtr[idx] = (btbCtr[idx] == 2'd3) ? 2'd3 : btbCtr[idx] + 2'd1;
            end else begin
                btbCtr[idx] = (btbCtr[idx] == 2'd0) ? 2'd0 : btbCtr[idx] - 2'd1;
            end
        end else if (taken) begin
            btbValid[idx]  = 1'b1;
            btbBlock[idx]  = pc[PC_W-1:SLOT_W];
            btbSlot[idx]   = pc[SLOT_W-1:0];
            btbTarget[idx] = target;
            btbJump[idx]   = isJump;
            btbCtr[idx]    = 2'd2;
        end
    endtask

    // Lookup sees the BTB as it was before this cycle's update
    task automatic modelCycle();
        logic [PC_W-1:0] nextPc;
        pendValid = 1'b0;
        if (redirectValid) begin
            modelPc      = redirectPc;
            modelFid     = redirectFid;
            modelFaulted = 1'b0;
        end else if (fetchEn && !modelFaulted) begin
            pendPkt   = refPacket(modelPc, modelFid, nextPc);
            pendValid = 1'b1;
            modelFid  = modelFid + FID_W'(1);
            if (pendPkt.fault == FAULT_ACCESS) begin
                modelFaulted = 1'b1;
            end else begin
                modelPc = nextPc;
            end
        end
        if (updValid) begin
            trainModel(updPc, updTarget, updTaken, updIsJump);
        end
    endtask

    task automatic doCycle(input logic en, input logic redir, input logic [PC_W-1:0] rPc,
                           input logic [FID_W-1:0] rFid, input logic upd,
                           input logic [PC_W-1:0] uPc, input logic [PC_W-1:0] uTgt,
                           input logic uTaken, input logic uJump);
        @(posedge clk);
        #1;
        shownValid    = pendValid;
        shownPkt      = pendPkt;
        loadValid     = 1'b0;
        fetchEn       = en;
        redirectValid = redir;
        redirectPc    = rPc;
        redirectFid   = rFid;
        updValid      = upd;
        updPc         = uPc;
        updTarget     = uTgt;
        updTaken      = uTaken;
        updIsJump     = uJump;
        modelCycle();
    endtask

    task automatic fetchCycle(input logic en);
        doCycle(en, 1'b0, '0, '0, 1'b0, '0, '0, 1'b0, 1'b0);
    endtask

    task automatic redirectCycle(input logic [PC_W-1:0] pc, input logic [FID_W-1:0] fid);
        doCycle(1'b1, 1'b1, pc, fid, 1'b0, '0, '0, 1'b0, 1'b0);
    endtask

    task automatic trainCycle(input logic [PC_W-1:0] pc, input logic [PC_W-1:0] target,
                              input logic taken, input logic isJump);
        doCycle(1'b0, 1'b0, '0, '0, 1'b1, pc, target, taken, isJump);
    endtask

    task automatic failRun();
        $display("test failed");
        $fatal(1);
    endtask

    task automatic reportMismatch(input string name, input logic [BLOCK_W-1:0] got,
                                  input logic [BLOCK_W-1:0] exp);
        $display("mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
        failRun();
    endtask

    task automatic reportError(input string msg);
        $display("%0t ns: %s", $time, msg);
        failRun();
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            if (shownValid) begin
                assert (outValid === 1'b1) else reportError("expected packet did not appear");
                assert (outPc === shownPkt.pc)
                    else reportMismatch("outPc", BLOCK_W'(outPc), BLOCK_W'(shownPkt.pc));
                assert (outFid === shownPkt.fid)
                    else reportMismatch("outFid", BLOCK_W'(outFid), BLOCK_W'(shownPkt.fid));
                assert (outInstrs === shownPkt.instrs)
                    else reportMismatch("outInstrs", outInstrs, shownPkt.instrs);
                assert (outFirstSlot === shownPkt.firstSlot)
                    else reportMismatch("outFirstSlot", BLOCK_W'(outFirstSlot),
                                        BLOCK_W'(shownPkt.firstSlot));
                assert (outLastSlot === shownPkt.lastSlot)
                    else reportMismatch("outLastSlot", BLOCK_W'(outLastSlot),
                                        BLOCK_W'(shownPkt.lastSlot));
                assert (outPredTaken === shownPkt.predTaken)
                    else reportMismatch("outPredTaken", BLOCK_W'(outPredTaken),
                                        BLOCK_W'(shownPkt.predTaken));
                assert (outPredTarget === shownPkt.predTarget)
                    else reportMismatch("outPredTarget", BLOCK_W'(outPredTarget),
                                        BLOCK_W'(shownPkt.predTarget));
                assert (outFault === shownPkt.fault)
                    else reportMismatch("outFault", BLOCK_W'(outFault), BLOCK_W'(shownPkt.fault));
            end else begin
                assert (outValid === 1'b0) else reportError("packet appeared when none was due");
            end
        end
    end

    initial begin
        #(TOTAL_CYCLES * 20);
        reportError("watchdog expired before all phases finished");
    end

    initial begin
        clk           = 1'b0;
        rst           = 1'b1;
        fetchEn       = 1'b0;
        loadValid     = 1'b0;
        loadAddr      = '0;
        loadData      = '0;
        updValid      = 1'b0;
        updPc         = '0;
        updTarget     = '0;
        updTaken      = 1'b0;
        updIsJump     = 1'b0;
        redirectValid = 1'b0;
        redirectPc    = '0;
        redirectFid   = '0;
        pendValid     = 1'b0;
        shownValid    = 1'b0;
        modelPc       = ENTRY_PC;
        modelFid      = '0;
        modelFaulted  = 1'b0;
        for (int i = 0; i < BTB_ENTRIES; i++) begin
            btbValid[i] = 1'b0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int b = 0; b < MEM_BLOCKS; b++) begin
            @(posedge clk);
            #1;
            loadValid = 1'b1;
            loadAddr  = BADDR_W'(b);
            loadData  = randomBlock();
            modelMem[loadAddr[MIDX_W-1:0]] = loadData;
        end

        // Empty BTB, straight-line fetch from the reset PC
        repeat (SEQ_CYCLES) fetchCycle(1'b1);

        for (int i = 0; i < TRAIN_COUNT; i++) begin
            trainedPc[i] = randPc();
            trainCycle(trainedPc[i], randPc(), 1'b1, randBit());
        end
        redirectCycle(ENTRY_PC, FID_W'(lcgNext()));
        repeat (RUN_CYCLES) fetchCycle(1'b1);

        // Two not-taken updates bring a fresh entry down to 0
        for (int i = 0; i < 4; i++) begin
            trainCycle(trainedPc[i], randPc(), 1'b0, 1'b0);
            trainCycle(trainedPc[i], randPc(), 1'b0, 1'b0);
        end
        redirectCycle(ENTRY_PC, FID_W'(lcgNext()));
        repeat (RUN_CYCLES) fetchCycle(1'b1);

        repeat (REDIRECT_ROUNDS) begin
            repeat (4) fetchCycle(1'b1);
            redirectCycle(randPc() | PC_W'(1), FID_W'(lcgNext()));
        end

        // Walk off the end of memory
        redirectCycle(PC_W'(44 * BLOCK_SLOTS), FID_W'(lcgNext()));
        repeat (10) fetchCycle(1'b1);

        redirectCycle(ENTRY_PC, FID_W'(lcgNext()));
        repeat (RANDOM_CYCLES) fetchCycle(randBit());
        repeat (2) fetchCycle(1'b0);

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/fetchSequencer_checker.sv
`timescale 1ns/1ps
`default_nettype none

module fetchSequencerChecker import fetchPkg::*; (
    input wire               clk,
    input wire               rst,
    input wire               outValid,
    input wire [BLOCK_W-1:0] outInstrs,
    input wire [1:0]         outFault,
    input wire               outOfRange,
    input wire               state
);

    // An out-of-range fetch yields a fault packet with no instructions
    faultZeroInstrs: assert property (@(posedge clk) disable iff (rst)
        (outValid && $past(outOfRange)) |-> (outFault == FAULT_ACCESS && outInstrs == '0))
    else $error("out-of-range fetch did not give a fault packet with zero instructions");

    // Only the fault packet itself may show once the sequencer has stopped
    silentWhenFaulted: assert property (@(posedge clk) disable iff (rst)
        (state == SEQ_FAULTED && $past(state) == SEQ_FAULTED) |-> !outValid)
    else $error("packet issued while faulted without a redirect");

    noPacketInReset: assert property (@(posedge clk) rst |=> !outValid)
    else $error("outValid high during reset");

endmodule

bind fetchSequencer fetchSequencerChecker fetchSequencerChecker_inst (
    .clk        (clk),
    .rst        (rst),
    .outValid   (outValid),
    .outInstrs  (outInstrs),
    .outFault   (outFault),
    .outOfRange (outOfRange),
    .state      (state)
);

`default_nettype wire

// File: design/instrFetch.sv
`timescale 1ns/1ps
`default_nettype none

module instrFetch import fetchPkg::*; #(
    parameter int MEM_BLOCKS  = 64,
    parameter int BTB_ENTRIES = 16
) (
    input  wire                clk,
    input  wire                rst,
    input  wire                fetchEn,
    input  wire                loadValid,
    input  wire [BADDR_W-1:0]  loadAddr,
    input  wire [BLOCK_W-1:0]  loadData,
    input  wire                updValid,
    input  wire [PC_W-1:0]     updPc,
    input  wire [PC_W-1:0]     updTarget,
    input  wire                updTaken,
    input  wire                updIsJump,
    input  wire                redirectValid,
    input  wire [PC_W-1:0]     redirectPc,
    input  wire [FID_W-1:0]    redirectFid,
    output logic               outValid,
    output logic [PC_W-1:0]    outPc,
    output logic [FID_W-1:0]   outFid,
    output logic [BLOCK_W-1:0] outInstrs,
    output logic [SLOT_W-1:0]  outFirstSlot,
    output logic [SLOT_W-1:0]  outLastSlot,
    output logic               outPredTaken,
    output logic [PC_W-1:0]    outPredTarget,
    output fetchFaultT         outFault
);

    logic [PC_W-1:0]    fetchPc;
    logic [BLOCK_W-1:0] blockData;
    logic               predHit;
    logic [SLOT_W-1:0]  predSlot;
    logic               predTaken;
    logic [PC_W-1:0]    predTarget;

    fetchBlockMemory #(
        .MEM_BLOCKS(MEM_BLOCKS)
    ) fetchBlockMemory_inst (
        .clk       (clk),
        .loadValid (loadValid),
        .loadAddr  (loadAddr),
        .loadData  (loadData),
        .fetchPc   (fetchPc),
        .blockData (blockData)
    );

    branchTargetBuffer #(
        .BTB_ENTRIES(BTB_ENTRIES)
    ) branchTargetBuffer_inst (
        .clk        (clk),
        .rst        (rst),
        .fetchPc    (fetchPc),
        .updValid   (updValid),
        .updPc      (updPc),
        .updTarget  (updTarget),
        .updTaken   (updTaken),
        .updIsJump  (updIsJump),
        .predHit    (predHit),
        .predSlot   (predSlot),
        .predTaken  (predTaken),
        .predTarget (predTarget)
    );

    fetchSequencer #(
        .MEM_BLOCKS(MEM_BLOCKS)
    ) fetchSequencer_inst (
        .clk           (clk),
        .rst           (rst),
        .fetchEn       (fetchEn),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc),
        .redirectFid   (redirectFid),
        .blockData     (blockData),
        .predHit       (predHit),
        .predSlot      (predSlot),
        .predTaken     (predTaken),
        .predTarget    (predTarget),
        .fetchPc       (fetchPc),
        .outValid      (outValid),
        .outPc         (outPc),
        .outFid        (outFid),
        .outInstrs     (outInstrs),
        .outFirstSlot  (outFirstSlot),
        .outLastSlot   (outLastSlot),
        .outPredTaken  (outPredTaken),
        .outPredTarget (outPredTarget),
        .outFault      (outFault)
    );

endmodule

`default_nettype wire

// File: design/fetchSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module fetchSequencer import fetchPkg::*; #(
    parameter int MEM_BLOCKS = 64
) (
    input  wire                clk,
    input  wire                rst,
    input  wire                fetchEn,
    input  wire                redirectValid,
    input  wire [PC_W-1:0]     redirectPc,
    input  wire [FID_W-1:0]    redirectFid,
    input  wire [BLOCK_W-1:0]  blockData,
    input  wire                predHit,
    input  wire [SLOT_W-1:0]   predSlot,
    input  wire                predTaken,
    input  wire [PC_W-1:0]     predTarget,
    output logic [PC_W-1:0]    fetchPc,
    output logic               outValid,
    output logic [PC_W-1:0]    outPc,
    output logic [FID_W-1:0]   outFid,
    output logic [BLOCK_W-1:0] outInstrs,
    output logic [SLOT_W-1:0]  outFirstSlot,
    output logic [SLOT_W-1:0]  outLastSlot,
    output logic               outPredTaken,
    output logic [PC_W-1:0]    outPredTarget,
    output fetchFaultT         outFault
);

    seqStateT state;

    logic [PC_W-1:0]  pc;
    logic [FID_W-1:0] fid;

    logic [BADDR_W-1:0] blockIdx;
    logic               outOfRange;
    logic               takenHit;
    logic               fetchActive;
    logic [PC_W-1:0]    nextPc;

    // One-stage register holding the fetch whose block arrives next cycle
    logic               pendValid;
    logic [PC_W-1:0]    pendPc;
    logic [FID_W-1:0]   pendFid;
    logic [SLOT_W-1:0]  pendLastSlot;
    logic               pendPredTaken;
    logic [PC_W-1:0]    pendPredTarget;
    fetchFaultT         pendFault;

    assign fetchPc = pc;

    assign blockIdx   = pc[PC_W-1:SLOT_W];
    assign outOfRange = (32'(blockIdx) >= MEM_BLOCKS);
    assign takenHit   = predHit && predTaken;

    // A redirect cancels whatever fetch would start this cycle
    assign fetchActive = fetchEn && (state == SEQ_FETCH) && !redirectValid;

    always_comb begin
        if (takenHit) begin
            nextPc = predTarget;
        end else begin
            nextPc = {blockIdx + BADDR_W'(1), SLOT_W'(0)};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= SEQ_FETCH;
            pc        <= ENTRY_PC;
            fid       <= '0;
            pendValid <= 1'b0;
        end else if (redirectValid) begin
            state     <= SEQ_FETCH;
            pc        <= redirectPc;
            fid       <= redirectFid;
            pendValid <= 1'b0;
        end else if (fetchActive) begin
            fid       <= fid + FID_W'(1);
            pendValid <= 1'b1;
            if (outOfRange) begin
                state <= SEQ_FAULTED;
            end else begin
                pc <= nextPc;
            end
        end else begin
            pendValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fetchActive) begin
            pendPc  <= pc;
            pendFid <= fid;
            if (outOfRange) begin
                pendFault      <= FAULT_ACCESS;
                pendLastSlot   <= LAST_SLOT;
                pendPredTaken  <= 1'b0;
                pendPredTarget <= '0;
            end else begin
                pendFault      <= FAULT_NONE;
                pendLastSlot   <= takenHit ? predSlot : LAST_SLOT;
                pendPredTaken  <= takenHit;
                pendPredTarget <= takenHit ? predTarget : '0;
            end
        end
    end

    // Packet merges the latched fetch with the block read out this cycle
    assign outValid      = pendValid;
    assign outPc         = pendPc;
    assign outFid        = pendFid;
    assign outFirstSlot  = pendPc[SLOT_W-1:0];
    assign outLastSlot   = pendLastSlot;
    assign outPredTaken  = pendPredTaken;
    assign outPredTarget = pendPredTarget;
    assign outFault      = pendFault;
    assign outInstrs     = (pendFault != FAULT_NONE) ? '0 : blockData;

endmodule

`default_nettype wire

// File: design/branchTargetBuffer.sv
`timescale 1ns/1ps
`default_nettype none

module branchTargetBuffer import fetchPkg::*; #(
    parameter int BTB_ENTRIES = 16
) (
    input  wire               clk,
    input  wire               rst,
    input  wire [PC_W-1:0]    fetchPc,
    input  wire               updValid,
    input  wire [PC_W-1:0]    updPc,
    input  wire [PC_W-1:0]    updTarget,
    input  wire               updTaken,
    input  wire               updIsJump,
    output logic              predHit,
    output logic [SLOT_W-1:0] predSlot,
    output logic              predTaken,
    output logic [PC_W-1:0]   predTarget
);

    localparam int IDX_W = (BTB_ENTRIES > 1) ? $clog2(BTB_ENTRIES) : 1;
    localparam int TAG_W = BADDR_W - IDX_W;

    logic [BTB_ENTRIES-1:0] entryValid;
    logic [TAG_W-1:0]       entryTag    [BTB_ENTRIES];
    logic [SLOT_W-1:0]      entrySlot   [BTB_ENTRIES];
    logic [PC_W-1:0]        entryTarget [BTB_ENTRIES];
    logic                   entryJump   [BTB_ENTRIES];
    logic [1:0]             entryCtr    [BTB_ENTRIES];

    logic [BADDR_W-1:0] lookBlock;
    logic [IDX_W-1:0]   lookIdx;
    logic [TAG_W-1:0]   lookTag;
    logic [SLOT_W-1:0]  lookSlot;

    logic [BADDR_W-1:0] updBlock;
    logic [IDX_W-1:0]   updIdx;
    logic [TAG_W-1:0]   updTag;
    logic               updHit;

    // Lookup side
    assign lookBlock = fetchPc[PC_W-1:SLOT_W];
    assign lookIdx   = lookBlock[IDX_W-1:0];
    assign lookTag   = lookBlock[BADDR_W-1:IDX_W];
    assign lookSlot  = fetchPc[SLOT_W-1:0];

    // A branch before the fetch slot is already behind us
    assign predHit    = entryValid[lookIdx] && (entryTag[lookIdx] == lookTag) &&
                        (entrySlot[lookIdx] >= lookSlot);
    assign predSlot   = entrySlot[lookIdx];
    assign predTaken  = entryJump[lookIdx] || entryCtr[lookIdx][1];
    assign predTarget = entryTarget[lookIdx];

    // Training side
    assign updBlock = updPc[PC_W-1:SLOT_W];
    assign updIdx   = updBlock[IDX_W-1:0];
    assign updTag   = updBlock[BADDR_W-1:IDX_W];
    assign updHit   = entryValid[updIdx] && (entryTag[updIdx] == updTag);

    always_ff @(posedge clk) begin
        if (rst) begin
            entryValid <= '0;
        end else if (updValid && !updHit && updTaken) begin
            entryValid[updIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (updValid) begin
            if (updHit) begin
                entryTarget[updIdx] <= updTarget;
                entryJump[updIdx]   <= updIsJump;
                // Saturating 2-bit counter
                if (updTaken && entryCtr[updIdx] != 2'd3) begin
                    entryCtr[updIdx] <= entryCtr[updIdx] + 2'd1;
                end else if (!updTaken && entryCtr[updIdx] != 2'd0) begin
                    entryCtr[updIdx] <= entryCtr[updIdx] - 2'd1;
                end
            end else if (updTaken) begin
                entryTag[updIdx]    <= updTag;
                entrySlot[updIdx]   <= updPc[SLOT_W-1:0];
                entryTarget[updIdx] <= updTarget;
                entryJump[updIdx]   <= updIsJump;
                entryCtr[updIdx]    <= 2'd2;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/fetchBlockMemory.sv
`timescale 1ns/1ps
`default_nettype none

module fetchBlockMemory import fetchPkg::*; #(
    parameter int MEM_BLOCKS = 64
) (
    input  wire                clk,
    input  wire                loadValid,
    input  wire [BADDR_W-1:0]  loadAddr,
    input  wire [BLOCK_W-1:0]  loadData,
    input  wire [PC_W-1:0]     fetchPc,
    output logic [BLOCK_W-1:0] blockData
);

    localparam int MIDX_W = (MEM_BLOCKS > 1) ? $clog2(MEM_BLOCKS) : 1;

    logic [BLOCK_W-1:0] mem [MEM_BLOCKS];

    logic [BADDR_W-1:0] readAddr;
    logic               readInRange;
    logic               loadInRange;

    assign readAddr = fetchPc[PC_W-1:SLOT_W];

    // Only the low index bits address the array once the range is known good
    assign readInRange = (32'(readAddr) < MEM_BLOCKS);
    assign loadInRange = (32'(loadAddr) < MEM_BLOCKS);

    always_ff @(posedge clk) begin
        if (loadValid && loadInRange) begin
            mem[loadAddr[MIDX_W-1:0]] <= loadData;
        end
    end

    // Block read is registered, data follows the address by one cycle
    always_ff @(posedge clk) begin
        if (readInRange) begin
            blockData <= mem[readAddr[MIDX_W-1:0]];
        end else begin
            blockData <= '0;
        end
    end

endmodule

`default_nettype wire

// File: design/fetchPkg.sv
`default_nettype none

package fetchPkg;

    // Program counter counts 16-bit parcels
    localparam int PC_W = 16;

    // Slot index inside a fetch block
    localparam int SLOT_W = 3;
    localparam int BLOCK_SLOTS = 8;

    localparam int PARCEL_W = 16;
    localparam int BLOCK_W = BLOCK_SLOTS * PARCEL_W;

    // Block address is the PC without the slot bits
    localparam int BADDR_W = PC_W - SLOT_W;

    localparam logic [PC_W-1:0] ENTRY_PC = '0;

    localparam int FID_W = 6;

    // Last slot of a block, used when no taken branch ends the packet early
    localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(BLOCK_SLOTS - 1);

    typedef enum logic [1:0] {
        FAULT_NONE   = 2'd0,
        FAULT_ACCESS = 2'd1
    } fetchFaultT;

    // Sequencer stops issuing after an access fault
    typedef enum logic {
        SEQ_FETCH   = 1'b0,
        SEQ_FAULTED = 1'b1
    } seqStateT;

endpackage

`default_nettype wire
